//--- src/wb_pkg.sv
`default_nettype none

package wb_pkg;

    localparam int num_slots   = 4;
    localparam int stq_depth   = 4;
    localparam int mem_credits = 2;

    // derived widths for the store queue
    localparam int stq_ptr_w = $clog2(stq_depth);
    localparam int stq_cnt_w = $clog2(stq_depth + 1);
    localparam int credit_w  = $clog2(mem_credits + 1);

    typedef struct packed {
        logic [63:0] data;
        logic [31:0] dest;      // low 3 bits index a register
        logic        is_reg;
        logic        is_seg;
        logic        is_mem;
        logic        wb;
        logic [6:0]  dest_tag;
    } wb_slot_t;

    typedef struct packed {
        logic        br_valid;
        logic        br_taken;
        logic        br_correct;
        logic [31:0] fip;       // resolved target
    } wb_branch_t;

    typedef struct packed {
        wb_slot_t [num_slots-1:0] slots;
        logic [1:0]               op_size;
        logic [3:0]               memsize_ovr; // one-hot
        logic [31:0]              eip;
        logic [31:0]              latched_eip;
        logic                     ld_eip_cs;   // far transfer
        logic                     halt;
        wb_branch_t               branch;
        logic [5:0]               bp_alias;
        logic [15:0]              cs;
        logic [17:0]              eflags;
        logic                     ie;
        logic [2:0]               ie_type;
        logic [6:0]               inst_id;
    } wb_op_t;

    // shared by the gpr and segment register files
    typedef struct packed {
        logic [num_slots-1:0]        ld;
        logic [num_slots-1:0][2:0]   addr;
        logic [num_slots-1:0][63:0]  data;
        logic [1:0]                  size;
    } wb_reg_write_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [63:0] data;
        logic [1:0]  size;
    } wb_store_t;

    typedef struct packed {
        logic       valid;
        logic [6:0] inst_id;
        logic [6:0] dest_tag;
    } wb_tag_t;

    typedef struct packed {
        logic [31:0] new_eip;
        logic [31:0] fip_even;
        logic [31:0] fip_odd;
        logic        resteer;
        logic [5:0]  bp_alias;
    } wb_redirect_t;

    typedef struct packed {
        logic       exc_valid;
        logic [3:0] exc_type;
    } wb_exc_t;

endpackage

`default_nettype wire

//--- src/wb_pipe_latch.sv
`timescale 1ns/1ps
`default_nettype none

module wb_pipe_latch
    import wb_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   ex_valid,
    input  wb_op_t ex_op,
    input  logic   stall,
    output logic   op_valid,
    output wb_op_t op
);

    logic load;

    // execute holds its op while stalled, so ex_op is ignored then
    assign load = ex_valid & ~stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid <= 1'b0;
        end else if (!stall) begin
            op_valid <= ex_valid; // empties when nothing new arrives
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op <= ex_op;
        end
    end

endmodule

`default_nettype wire

//--- src/wb_dest_decode.sv
`timescale 1ns/1ps
`default_nettype none

module wb_dest_decode
    import wb_pkg::*;
(
    input  logic                    op_valid,
    input  wb_op_t                  op,
    output wb_reg_write_t           reg_wr,
    output wb_reg_write_t           seg_wr,
    output wb_tag_t [num_slots-1:0] tags,
    output logic                    store_req,
    output wb_store_t               store
);

    logic [num_slots-1:0]       reg_ld;
    logic [num_slots-1:0]       seg_ld;
    logic [num_slots-1:0]       mem_ld;
    logic [num_slots-1:0][63:0] slot_data;
    logic [num_slots-1:0][2:0]  slot_idx;
    logic [1:0]                 mem_size;

    always_comb begin
        for (int i = 0; i < num_slots; i++) begin
            reg_ld[i]    = op_valid & op.slots[i].wb & op.slots[i].is_reg;
            seg_ld[i]    = op_valid & op.slots[i].wb & op.slots[i].is_seg;
            mem_ld[i]    = op_valid & op.slots[i].wb & op.slots[i].is_mem;
            slot_data[i] = op.slots[i].data;
            slot_idx[i]  = op.slots[i].dest[2:0];
        end
        // far transfer carries the new cs selector in bits 47:32
        if (op.ld_eip_cs)
            slot_data[0] = {48'd0, op.slots[0].data[47:32]};
    end

    assign reg_wr.ld   = reg_ld;
    assign reg_wr.addr = slot_idx;
    assign reg_wr.data = slot_data;
    assign reg_wr.size = op.op_size;

    assign seg_wr.ld   = seg_ld;
    assign seg_wr.addr = slot_idx;
    assign seg_wr.data = slot_data;
    assign seg_wr.size = op.op_size;

    always_comb begin
        for (int i = 0; i < num_slots; i++) begin
            tags[i].valid    = reg_ld[i] | seg_ld[i] | mem_ld[i];
            tags[i].inst_id  = op.inst_id;
            tags[i].dest_tag = op.slots[i].dest_tag;
        end
    end

    // override first, then far transfer, then the op size
    always_comb begin
        if (op.memsize_ovr[0])
            mem_size = 2'd0;
        else if (op.memsize_ovr[1])
            mem_size = 2'd1;
        else if (op.memsize_ovr[2])
            mem_size = 2'd2;
        else if (op.memsize_ovr[3])
            mem_size = 2'd3;
        else if (op.ld_eip_cs)
            mem_size = 2'd3;
        else
            mem_size = op.op_size;
    end

    assign store_req = |mem_ld;

    always_comb begin
        store = '0;
        for (int i = num_slots - 1; i >= 0; i--) begin // lowest index wins
            if (mem_ld[i]) begin
                store.addr = op.slots[i].dest;
                store.data = slot_data[i];
            end
        end
        store.size = mem_size;
    end

endmodule

`default_nettype wire

//--- src/wb_branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module wb_branch_resolve
    import wb_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         fire,
    input  wb_op_t       op,
    output wb_redirect_t redirect
);

    logic [31:0] target_eip;
    logic [31:0] line_base;
    logic [31:0] line_next;
    logic        mispredict;
    logic        resteer_q;

    // far jumps take their eip from slot 0
    assign target_eip = op.ld_eip_cs ? op.slots[0].data[31:0] : op.branch.fip;

    assign line_base = {op.branch.fip[31:4], 4'd0};
    assign line_next = line_base + 32'd16;

    assign redirect.new_eip  = op.branch.br_taken ? target_eip : op.eip;
    // bit 4 says whether fip sits in an odd line
    assign redirect.fip_even = op.branch.fip[4] ? line_next : line_base;
    assign redirect.fip_odd  = op.branch.fip[4] ? line_base : line_next;
    assign redirect.bp_alias = op.bp_alias;
    assign redirect.resteer  = resteer_q;

    assign mispredict = fire & op.branch.br_valid & ~op.branch.br_correct;

    always_ff @(posedge clk) begin
        if (reset) begin
            resteer_q <= 1'b0;
        end else begin
            resteer_q <= mispredict; // one cycle pulse
        end
    end

endmodule

`default_nettype wire

//--- src/wb_store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module wb_store_queue
    import wb_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      push,
    input  wb_store_t entry,
    input  logic      mem_credit,
    output logic      full,
    output logic      mem_store_valid,
    output wb_store_t mem_store
);

    wb_store_t            entries [stq_depth];
    logic [stq_ptr_w-1:0] wr_ptr;
    logic [stq_ptr_w-1:0] rd_ptr;
    logic [stq_cnt_w-1:0] count;
    logic [credit_w-1:0]  credits;
    logic                 send;

    assign full = (count == stq_cnt_w'(stq_depth));

    // drain one per cycle while memory has room
    assign send = (count != '0) && (credits != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            credits         <= credit_w'(mem_credits);
            mem_store_valid <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            if (send)
                rd_ptr <= rd_ptr + 1'b1;
            count           <= count + stq_cnt_w'(push) - stq_cnt_w'(send);
            credits         <= credits + credit_w'(mem_credit) - credit_w'(send);
            mem_store_valid <= send;
        end
    end

    // push trusts the stage to have checked full
    always_ff @(posedge clk) begin
        if (push)
            entries[wr_ptr] <= entry;
        if (send)
            mem_store <= entries[rd_ptr];
    end

endmodule

`default_nettype wire

//--- src/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage
    import wb_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    op_valid,
    input  wb_op_t                  op,
    input  logic                    stq_full,
    input  logic                    interrupt,
    output logic                    stall,
    output wb_reg_write_t           reg_wr,
    output wb_reg_write_t           seg_wr,
    output wb_tag_t [num_slots-1:0] tags,
    output logic                    stq_push,
    output wb_store_t               stq_entry,
    output wb_redirect_t            redirect,
    output wb_exc_t                 exc,
    output logic                    halt,
    output logic [15:0]             cs_out,
    output logic [17:0]             eflags_out,
    output logic [31:0]             eip_out,
    output logic [31:0]             latched_eip_out
);

    logic [num_slots-1:0] store_hit;
    logic                 fire;

    // raw store request, taken before fire to keep stall free of loops
    always_comb begin
        for (int i = 0; i < num_slots; i++)
            store_hit[i] = op.slots[i].is_mem & op.slots[i].wb;
    end

    assign stall = op_valid & (|store_hit) & stq_full;
    assign fire  = op_valid & ~stall;

    wb_dest_decode u_decode (
        .op_valid  (fire),
        .op        (op),
        .reg_wr    (reg_wr),
        .seg_wr    (seg_wr),
        .tags      (tags),
        .store_req (stq_push),
        .store     (stq_entry)
    );

    wb_branch_resolve u_branch (
        .clk      (clk),
        .reset    (reset),
        .fire     (fire),
        .op       (op),
        .redirect (redirect)
    );

    assign exc.exc_valid = ~stall & ((op_valid & op.ie) | interrupt);
    assign exc.exc_type  = {interrupt, op.ie_type}; // interrupt on top

    assign halt = fire & op.halt;

    assign cs_out          = op.cs;
    assign eflags_out      = op.eflags;
    assign eip_out         = op.eip;
    assign latched_eip_out = op.latched_eip;

endmodule

`default_nettype wire

//--- src/writeback_top.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_top
    import wb_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ex_valid,
    input  wb_op_t                  ex_op,
    input  logic                    interrupt,
    input  logic                    mem_credit,
    output logic                    stall,
    output wb_reg_write_t           reg_wr,
    output wb_reg_write_t           seg_wr,
    output wb_tag_t [num_slots-1:0] tags,
    output wb_redirect_t            redirect,
    output wb_exc_t                 exc,
    output logic                    halt,
    output logic [15:0]             cs_out,
    output logic [17:0]             eflags_out,
    output logic [31:0]             eip_out,
    output logic [31:0]             latched_eip_out,
    output logic                    mem_store_valid,
    output wb_store_t               mem_store
);

    logic      op_valid;
    wb_op_t    op;
    logic      stq_full;
    logic      stq_push;
    wb_store_t stq_entry;

    wb_pipe_latch u_latch (
        .clk      (clk),
        .reset    (reset),
        .ex_valid (ex_valid),
        .ex_op    (ex_op),
        .stall    (stall),
        .op_valid (op_valid),
        .op       (op)
    );

    writeback_stage u_stage (
        .clk             (clk),
        .reset           (reset),
        .op_valid        (op_valid),
        .op              (op),
        .stq_full        (stq_full),
        .interrupt       (interrupt),
        .stall           (stall),
        .reg_wr          (reg_wr),
        .seg_wr          (seg_wr),
        .tags            (tags),
        .stq_push        (stq_push),
        .stq_entry       (stq_entry),
        .redirect        (redirect),
        .exc             (exc),
        .halt            (halt),
        .cs_out          (cs_out),
        .eflags_out      (eflags_out),
        .eip_out         (eip_out),
        .latched_eip_out (latched_eip_out)
    );

    wb_store_queue u_stq (
        .clk             (clk),
        .reset           (reset),
        .push            (stq_push),
        .entry           (stq_entry),
        .mem_credit      (mem_credit),
        .full            (stq_full),
        .mem_store_valid (mem_store_valid),
        .mem_store       (mem_store)
    );

endmodule

`default_nettype wire

//--- dv/tb_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module tb_writeback
    import wb_pkg::*;
;

    logic                    clk;
    logic                    reset;
    logic                    ex_valid;
    wb_op_t                  ex_op;
    logic                    interrupt;
    logic                    mem_credit;
    logic                    stall;
    wb_reg_write_t           reg_wr;
    wb_reg_write_t           seg_wr;
    wb_tag_t [num_slots-1:0] tags;
    wb_redirect_t            redirect;
    wb_exc_t                 exc;
    logic                    halt;
    logic [15:0]             cs_out;
    logic [17:0]             eflags_out;
    logic [31:0]             eip_out;
    logic [31:0]             latched_eip_out;
    logic                    mem_store_valid;
    wb_store_t               mem_store;

    logic [31:0] seed = 32'ha78c_843c;
    int          checks = 0;
    int          errors = 0;
    wb_store_t   got_q[$];
    wb_store_t   exp_q[$];

    writeback_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // sampled on the edge that ends the pulse
    always @(posedge clk) begin
        if (!reset && mem_store_valid)
            got_q.push_back(mem_store);
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic wb_op_t random_op();
        wb_op_t      op;
        logic [31:0] r;
        op = '0;
        for (int i = 0; i < num_slots; i++) begin
            r = lcg_next();
            op.slots[i].data     = {lcg_next(), lcg_next()};
            op.slots[i].dest     = lcg_next();
            op.slots[i].is_reg   = r[0];
            op.slots[i].is_seg   = r[1];
            op.slots[i].wb       = r[2] | r[3]; // mostly writing
            op.slots[i].dest_tag = r[10:4];
        end
        r = lcg_next();
        op.op_size     = r[1:0];
        op.inst_id     = r[8:2];
        op.bp_alias    = r[14:9];
        op.cs          = r[31:16];
        op.eip         = lcg_next();
        op.latched_eip = lcg_next();
        r = lcg_next();
        op.eflags      = r[17:0];
        op.branch.fip  = lcg_next();
        return op;
    endfunction

    function automatic logic [63:0] slot_value(wb_op_t op, int i);
        if (i == 0 && op.ld_eip_cs)
            return {48'd0, op.slots[0].data[47:32]}; // cs selector
        return op.slots[i].data;
    endfunction

    function automatic wb_reg_write_t exp_writes(wb_op_t op, logic seg);
        wb_reg_write_t w;
        w = '0;
        for (int i = 0; i < num_slots; i++) begin
            w.ld[i]   = op.slots[i].wb & (seg ? op.slots[i].is_seg : op.slots[i].is_reg);
            w.addr[i] = op.slots[i].dest[2:0];
            w.data[i] = slot_value(op, i);
        end
        w.size = op.op_size;
        return w;
    endfunction

    function automatic wb_tag_t exp_tag(wb_op_t op, int i);
        wb_tag_t t;
        t.valid    = op.slots[i].wb
                     & (op.slots[i].is_reg | op.slots[i].is_seg | op.slots[i].is_mem);
        t.inst_id  = op.inst_id;
        t.dest_tag = op.slots[i].dest_tag;
        return t;
    endfunction

    function automatic wb_store_t exp_store(wb_op_t op);
        wb_store_t s;
        logic      found;
        s = '0;
        found = 1'b0;
        for (int i = 0; i < num_slots; i++) begin
            if (!found && op.slots[i].is_mem && op.slots[i].wb) begin
                s.addr = op.slots[i].dest;
                s.data = slot_value(op, i);
                found = 1'b1;
            end
        end
        casez (op.memsize_ovr)
            4'b???1: s.size = 2'd0;
            4'b??10: s.size = 2'd1;
            4'b?100: s.size = 2'd2;
            4'b1000: s.size = 2'd3;
            default: s.size = op.ld_eip_cs ? 2'd3 : op.op_size;
        endcase
        return s;
    endfunction

    function automatic wb_redirect_t exp_redirect(wb_op_t op, logic resteer);
        wb_redirect_t r;
        logic [31:0]  line;
        line = op.branch.fip & 32'hffff_fff0;
        if (op.branch.br_taken)
            r.new_eip = op.ld_eip_cs ? op.slots[0].data[31:0] : op.branch.fip;
        else
            r.new_eip = op.eip;
        r.fip_even = op.branch.fip[4] ? line + 32'd16 : line;
        r.fip_odd  = op.branch.fip[4] ? line : line + 32'd16;
        r.resteer  = resteer;
        r.bp_alias = op.bp_alias;
        return r;
    endfunction

    task automatic check_reg_write(string name, wb_reg_write_t got, wb_reg_write_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_store(string name, wb_store_t got, wb_store_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_redirect(string name, wb_redirect_t got, wb_redirect_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_tags(string name, wb_tag_t got, wb_tag_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_exc(string name, wb_exc_t got, wb_exc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic stop_on_timeout(string what);
        $display("timeout while waiting for %s", what);
        $display("Checks failed");
        $finish;
    endtask

    // returns at the falling edge of the cycle in which op sits in the latch
    task automatic send_op(wb_op_t op);
        @(posedge clk);
        ex_valid <= 1'b1;
        ex_op    <= op;
        @(posedge clk);
        ex_valid <= 1'b0;
        @(negedge clk);
    endtask

    task automatic pulse_credit(int n);
        repeat (n) begin
            @(posedge clk);
            mem_credit <= 1'b1;
            @(posedge clk);
            mem_credit <= 1'b0;
        end
    endtask

    task automatic wait_stores(int n);
        int t;
        t = 0;
        while (got_q.size() < n && t < 50) begin
            @(negedge clk);
            t++;
        end
        if (got_q.size() < n)
            stop_on_timeout("stores to reach memory");
    endtask

    task automatic compare_stores(string name);
        check_count({name, " store count"}, got_q.size(), exp_q.size());
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++)
            check_store($sformatf("%s mem_store[%0d]", name, i), got_q[i], exp_q[i]);
    endtask

    task automatic check_all_writes(wb_op_t op);
        check_reg_write("reg_wr", reg_wr, exp_writes(op, 1'b0));
        check_reg_write("seg_wr", seg_wr, exp_writes(op, 1'b1));
        for (int i = 0; i < num_slots; i++)
            check_tags($sformatf("tags[%0d]", i), tags[i], exp_tag(op, i));
    endtask

    // state that passes straight through from the latched op
    task automatic check_passthrough(wb_op_t op);
        check_word("cs_out", 32'(cs_out), 32'(op.cs));
        check_word("eflags_out", 32'(eflags_out), 32'(op.eflags));
        check_word("eip_out", eip_out, op.eip);
        check_word("latched_eip_out", latched_eip_out, op.latched_eip);
    endtask

    task automatic end_test(string name, int c0, int e0);
        $display("%s: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    task automatic test_reg_seg_writes();
        wb_op_t op;
        int     c0;
        int     e0;
        c0 = checks;
        e0 = errors;
        repeat (8) begin
            op = random_op();
            send_op(op);
            check_all_writes(op);
            check_passthrough(op);
        end
        end_test("reg_seg_writes", c0, e0);
    endtask

    task automatic test_stores_credits();
        wb_op_t op;
        int     c0;
        int     e0;
        c0 = checks;
        e0 = errors;
        got_q.delete();
        exp_q.delete();
        for (int k = 0; k < 3; k++) begin
            op = random_op();
            op.slots[1].is_mem = 1'b1;
            op.slots[1].wb     = 1'b1;
            op.slots[3].is_mem = 1'b1;
            if (k == 1) begin
                op.slots[0].is_mem = 1'b1; // lower slot must win
                op.slots[0].wb     = 1'b1;
            end
            if (k == 2) begin
                op.memsize_ovr = 4'b0100;
                op.op_size     = 2'd1;
            end
            exp_q.push_back(exp_store(op));
            send_op(op);
            check_bit("stall", stall, 1'b0);
        end
        repeat (6) @(negedge clk);
        check_count("stores without credit", got_q.size(), mem_credits);
        pulse_credit(1);
        wait_stores(3);
        repeat (3) @(negedge clk);
        compare_stores("stores_credits");
        pulse_credit(2); // back to full credit
        end_test("stores_credits", c0, e0);
    endtask

    task automatic test_backpressure();
        wb_op_t op;
        int     c0;
        int     e0;
        int     t;
        c0 = checks;
        e0 = errors;
        got_q.delete();
        exp_q.delete();
        // two drain on the spare credits, four fill the queue
        repeat (mem_credits + stq_depth) begin
            op = random_op();
            op.slots[2].is_mem = 1'b1;
            op.slots[2].wb     = 1'b1;
            exp_q.push_back(exp_store(op));
            send_op(op);
        end
        op = random_op();
        op.slots[0].is_mem = 1'b1;
        op.slots[0].wb     = 1'b1;
        exp_q.push_back(exp_store(op));
        send_op(op);
        check_bit("stall on full queue", stall, 1'b1);
        check_bit("writes while stalled",
                  |{reg_wr.ld, seg_wr.ld, tags[0].valid, tags[1].valid,
                    tags[2].valid, tags[3].valid}, 1'b0);
        pulse_credit(1);
        t = 0;
        @(negedge clk);
        while (stall && t < 20) begin
            @(negedge clk);
            t++;
        end
        if (stall)
            stop_on_timeout("stall to clear");
        check_all_writes(op);
        pulse_credit(mem_credits + stq_depth);
        wait_stores(exp_q.size());
        repeat (4) @(negedge clk);
        compare_stores("backpressure");
        end_test("backpressure", c0, e0);
    endtask

    task automatic test_branch();
        wb_op_t op;
        int     c0;
        int     e0;
        c0 = checks;
        e0 = errors;
        for (int k = 0; k < 6; k++) begin
            op = random_op();
            op.branch.br_valid   = 1'b1;
            op.branch.br_taken   = k[0];
            op.branch.br_correct = (k == 2 || k == 3);
            send_op(op);
            check_redirect("redirect", redirect, exp_redirect(op, 1'b0));
            @(negedge clk);
            check_bit("resteer", redirect.resteer, !op.branch.br_correct);
            @(negedge clk);
            check_bit("resteer after pulse", redirect.resteer, 1'b0);
        end
        end_test("branch", c0, e0);
    endtask

    task automatic test_far_transfer();
        wb_op_t op;
        int     c0;
        int     e0;
        c0 = checks;
        e0 = errors;
        got_q.delete();
        exp_q.delete();
        for (int k = 0; k < 2; k++) begin
            op = random_op();
            op.op_size           = 2'd0;
            op.ld_eip_cs         = 1'b1;
            op.branch.br_valid   = 1'b1;
            op.branch.br_taken   = 1'b1;
            op.branch.br_correct = 1'b1;
            op.slots[0].is_seg   = 1'b1;
            op.slots[0].is_reg   = 1'b0;
            op.slots[0].wb       = 1'b1;
            op.slots[0].dest     = 32'd1; // cs
            op.slots[2].is_mem   = 1'b1;
            op.slots[2].wb       = 1'b1;
            if (k == 1) begin
                op.memsize_ovr     = 4'b0010;
                op.slots[0].is_mem = 1'b1; // store carries the selector
            end
            exp_q.push_back(exp_store(op));
            send_op(op);
            check_all_writes(op);
            check_redirect("far redirect", redirect, exp_redirect(op, 1'b0));
        end
        wait_stores(2);
        repeat (3) @(negedge clk);
        compare_stores("far_transfer");
        pulse_credit(2);
        end_test("far_transfer", c0, e0);
    endtask

    task automatic test_exc_halt();
        wb_op_t  op;
        wb_exc_t e;
        int      c0;
        int      e0;
        c0 = checks;
        e0 = errors;
        op = random_op();
        op.ie      = 1'b1;
        op.ie_type = 3'd5;
        op.halt    = 1'b1;
        send_op(op);
        e.exc_valid = 1'b1;
        e.exc_type  = 4'b0101;
        check_exc("exc from ie", exc, e);
        check_bit("halt", halt, 1'b1);
        op = random_op();
        op.ie_type = 3'd2;
        @(posedge clk);
        interrupt <= 1'b1;
        send_op(op);
        e.exc_type = 4'b1010; // interrupt above ie_type
        check_exc("exc from interrupt", exc, e);
        check_bit("halt without flag", halt, 1'b0);
        @(posedge clk);
        interrupt <= 1'b0;
        @(negedge clk);
        check_bit("exc_valid idle", exc.exc_valid, 1'b0);
        check_bit("halt idle", halt, 1'b0);
        end_test("exc_halt", c0, e0);
    endtask

    initial begin
        reset      = 1'b1;
        ex_valid   = 1'b0;
        ex_op      = '0;
        interrupt  = 1'b0;
        mem_credit = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("stall after reset", stall, 1'b0);
        check_bit("resteer after reset", redirect.resteer, 1'b0);
        check_bit("mem_store_valid after reset", mem_store_valid, 1'b0);
        test_reg_seg_writes();
        test_stores_credits();
        test_backpressure();
        test_branch();
        test_far_transfer();
        test_exc_halt();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
src/wb_pkg.sv
src/wb_pipe_latch.sv
src/wb_dest_decode.sv
src/wb_branch_resolve.sv
src/wb_store_queue.sv
src/writeback_stage.sv
src/writeback_top.sv
dv/tb_writeback.sv
